// ==== design/apb_addr_decode.sv ====
`timescale 1ns/1ps

module apb_addr_decode
    import memory_map_pkg::*;
#(
    parameter int RAM_BITS = 8,
    parameter int ROM_BITS = 5
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  addr_t    paddr,
    input  word_t    pwdata,
    input  strb_t    pstrb,
    output mem_req_t req
);

    localparam int REGION_LSB = $bits(addr_t) - $bits(region_t);

    logic setup;
    region_t region;
    logic [REGION_LSB-3:0] word_index;
    logic bad_region;
    logic ram_range_err;
    logic rom_range_err;
    logic rom_write;
    logic error;
    mem_req_t req_d;

    // First cycle of a transfer.
    assign setup = psel && !penable;

    assign region = paddr[$bits(addr_t)-1:REGION_LSB];
    assign word_index = paddr[REGION_LSB-1:2];

    ////////////////////////////////////////////////////////////
    // Region and range checks.
    ////////////////////////////////////////////////////////////

    always_comb begin
        bad_region = (region != REGION_ROM) && (region != REGION_RAM) &&
                     (region != REGION_PORT);
        ram_range_err = (region == REGION_RAM) && ((word_index >> RAM_BITS) != '0);
        rom_range_err = (region == REGION_ROM) && ((word_index >> ROM_BITS) != '0);
        rom_write = (region == REGION_ROM) && pwrite;
        error = bad_region || ram_range_err || rom_range_err || rom_write;
    end

    always_comb begin
        req_d = '0;
        req_d.valid = 1'b1;
        // A port write without byte 0 has no effect and travels as a read.
        req_d.write = pwrite && !((region == REGION_PORT) && !pstrb[0]);
        req_d.region = region;
        req_d.addr = paddr;
        req_d.wdata = pwdata;
        req_d.error = error;
        if (pwrite && (region == REGION_RAM) && !error) begin
            req_d.lane_we = pstrb;
        end
    end

    ////////////////////////////////////////////////////////////
    // Request register, valid for one cycle.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            req <= '0;
        end else if (setup) begin
            req <= req_d;
        end else begin
            req.valid <= 1'b0;
            req.lane_we <= '0;
        end
    end

    // Access phase only inside a selected transfer.
    penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset)
        penable |-> psel
    ) else $error("penable high without psel");

endmodule

// ==== design/apb_response.sv ====
`timescale 1ns/1ps

module apb_response
    import memory_map_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  mem_req_t              req,
    input  byte_t [NUM_LANES-1:0] lane_rdata,
    input  word_t                 rom_rdata,
    output word_t                 prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic [1:0]            led
);

    // Request lined up with the registered read data.
    mem_req_t req_q;
    word_t ram_word;
    logic port_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= '0;
        end else begin
            req_q <= req;
        end
    end

    ////////////////////////////////////////////////////////////
    // LED port.
    ////////////////////////////////////////////////////////////

    assign port_write = req.valid && req.write && !req.error &&
                        (req.region == REGION_PORT);

    always_ff @(posedge clk) begin
        if (reset) begin
            led <= '0;
        end else if (port_write) begin
            led <= req.wdata[1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Reply.
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            ram_word[i*$bits(byte_t) +: $bits(byte_t)] = lane_rdata[i];
        end
    end

    assign pready = req_q.valid;
    assign pslverr = req_q.valid && req_q.error;

    // Zero outside the reply cycle and on errors.
    always_comb begin
        prdata = '0;
        if (req_q.valid && !req_q.error) begin
            case (req_q.region)
                REGION_RAM: prdata = ram_word;
                REGION_ROM: prdata = rom_rdata;
                REGION_PORT: prdata = word_t'(led);
                default: prdata = '0;
            endcase
        end
    end

    // One reply per transfer.
    single_cycle_ready: assert property (
        @(posedge clk) disable iff (reset)
        pready |=> !pready
    ) else $error("pready high for two cycles");

endmodule

// ==== design/memory_map_pkg.sv ====
package memory_map_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths.
    ////////////////////////////////////////////////////////////

    // Bytes in one bus word.
    localparam int NUM_LANES = 4;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [NUM_LANES-1:0] strb_t;
    typedef logic [7:0] byte_t;

    // Region selector, address bits 31 to 28.
    typedef logic [3:0] region_t;

    ////////////////////////////////////////////////////////////
    // Memory map.
    ////////////////////////////////////////////////////////////

    // Read-only program store.
    localparam region_t REGION_ROM = 4'd1;

    // Data RAM, one memory per byte lane.
    localparam region_t REGION_RAM = 4'd2;

    // Two-bit LED port.
    localparam region_t REGION_PORT = 4'd3;

    ////////////////////////////////////////////////////////////
    // Request from the decoder to the memories.
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic valid;
        logic write;
        region_t region;
        addr_t addr;
        word_t wdata;
        // Per-lane write enables, RAM writes only.
        strb_t lane_we;
        // Unmapped region, ROM write or address past the end.
        logic error;
    } mem_req_t;

endpackage

// ==== design/memory_map_top.sv ====
`timescale 1ns/1ps

module memory_map_top
    import memory_map_pkg::*;
#(
    parameter int RAM_BITS = 8,
    parameter int ROM_BITS = 5
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  addr_t      paddr,
    input  word_t      pwdata,
    input  strb_t      pstrb,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr,
    output logic [1:0] led
);

    mem_req_t req;
    byte_t [NUM_LANES-1:0] lane_rdata;
    word_t rom_rdata;

    ////////////////////////////////////////////////////////////
    // Setup phase to request.
    ////////////////////////////////////////////////////////////

    apb_addr_decode #(
        .RAM_BITS(RAM_BITS),
        .ROM_BITS(ROM_BITS)
    ) apb_addr_decode_inst (
        .clk(clk),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .pstrb(pstrb),
        .req(req)
    );

    ////////////////////////////////////////////////////////////
    // Memories.
    ////////////////////////////////////////////////////////////

    // Data RAM, lane i holds byte i of each word.
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        ram_byte_lane #(
            .RAM_BITS(RAM_BITS)
        ) ram_byte_lane_inst (
            .clk(clk),
            .we(req.lane_we[i]),
            .word_addr(req.addr[RAM_BITS+1:2]),
            .wbyte(req.wdata[i*$bits(byte_t) +: $bits(byte_t)]),
            .rbyte(lane_rdata[i])
        );
    end

    rom_store #(
        .ROM_BITS(ROM_BITS)
    ) rom_store_inst (
        .clk(clk),
        .reset(reset),
        .req(req),
        .rword(rom_rdata)
    );

    ////////////////////////////////////////////////////////////
    // Reply and LED port.
    ////////////////////////////////////////////////////////////

    apb_response apb_response_inst (
        .clk(clk),
        .reset(reset),
        .req(req),
        .lane_rdata(lane_rdata),
        .rom_rdata(rom_rdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .led(led)
    );

endmodule

// ==== design/ram_byte_lane.sv ====
`timescale 1ns/1ps

module ram_byte_lane
    import memory_map_pkg::*;
#(
    parameter int RAM_BITS = 8
) (
    input  logic                clk,
    input  logic                we,
    input  logic [RAM_BITS-1:0] word_addr,
    input  byte_t               wbyte,
    output byte_t               rbyte
);

    localparam int DEPTH = 1 << RAM_BITS;

    // One byte of every RAM word.
    byte_t mem [DEPTH];

    ////////////////////////////////////////////////////////////
    // Read-before-write port.
    ////////////////////////////////////////////////////////////

    // Old contents come back even on a write cycle.
    always_ff @(posedge clk) begin
        rbyte <= mem[word_addr];
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_addr] <= wbyte;
        end
    end

endmodule

// ==== design/rom_store.sv ====
`timescale 1ns/1ps

module rom_store
    import memory_map_pkg::*;
#(
    parameter int ROM_BITS = 5
) (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t req,
    output word_t    rword
);

    localparam int DEPTH = 1 << ROM_BITS;

    word_t rom [DEPTH];
    logic rom_read;

    // Program image.
    initial begin
        $readmemh("rom_init.hex", rom);
    end

    assign rom_read = req.valid && !req.error && (req.region == REGION_ROM);

    always_ff @(posedge clk) begin
        if (reset) begin
            rword <= '0;
        end else if (rom_read) begin
            rword <= rom[req.addr[ROM_BITS+1:2]];
        end
    end

    // Decoder never turns a ROM access into a lane write.
    no_rom_lane_write: assert property (
        @(posedge clk) disable iff (reset)
        (req.lane_we != '0) |-> (req.region != REGION_ROM)
    ) else $error("lane write enabled for a ROM request");

endmodule

// ==== dv/memory_map_tb.sv ====
`timescale 1ns/1ps

module memory_map_tb
    import memory_map_pkg::*;
;

    localparam int RAM_BITS = 8;
    localparam int ROM_BITS = 5;
    localparam int RAM_WORDS = 1 << RAM_BITS;
    localparam int ROM_WORDS = 1 << ROM_BITS;
    localparam int RAM_SLOTS = 16;
    localparam int STROBE_WRITES = 32;
    localparam int PORT_TRANSFERS = 6;
    localparam int ERROR_TRANSFERS = 2 * 13 + 4 + 1;
    // Setup, access, reply and idle cycle of one transfer.
    localparam int TRANSFER_CYCLES = 4;
    localparam int TEST_CYCLES = 4 + TRANSFER_CYCLES * (2 * ROM_WORDS + 3 * RAM_SLOTS +
        STROBE_WRITES + PORT_TRANSFERS + ERROR_TRANSFERS);
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic clk;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    addr_t paddr;
    word_t pwdata;
    strb_t pstrb;
    word_t prdata;
    logic pready;
    logic pslverr;
    logic [1:0] led;

    logic [31:0] lfsr_state = 32'h0e504cfe;
    int cycle_count = 0;
    word_t ram_model [RAM_WORDS];
    word_t rom_model [ROM_WORDS];
    int slot_index [RAM_SLOTS];

    memory_map_top #(
        .RAM_BITS(RAM_BITS),
        .ROM_BITS(ROM_BITS)
    ) memory_map_top_inst (
        .clk(clk),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .pstrb(pstrb),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Run timed out after %0d cycles", cycle_count));
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers.
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // Galois LFSR, x^32 + x^30 + x^26 + x^25 + 1.
    function automatic word_t random_bits(input int count);
        word_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | word_t'(lfsr_state[0]);
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    function automatic addr_t ram_address(input int index);
        return {REGION_RAM, 28'(index * 4)};
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s read %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_error(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s flag %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_led(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s led %b, expected %b", $time, what, got, exp));
        end
    endtask

    // One APB transfer, also checking the two-cycle access phase.
    task automatic run_transfer(input logic write, input addr_t addr, input word_t data,
                                input strb_t strb, output word_t rdata, output logic err);
        int waited;
        waited = 0;
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = data;
        pstrb = write ? strb : '0;
        @(negedge clk);
        check_error(pready, 1'b0, "pready in setup");
        penable = 1'b1;
        do begin
            @(negedge clk);
            waited++;
        end while (!pready);
        if (waited != 1) begin
            abort_run($sformatf("FAILED at %0t: pready came %0d cycles after access start",
                                $time, waited));
        end
        rdata = prdata;
        err = pslverr;
        @(negedge clk);
        check_error(pready, 1'b0, "pready after reply");
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input addr_t addr, input word_t data, input strb_t strb,
                             output logic err);
        word_t unused;
        run_transfer(1'b1, addr, data, strb, unused, err);
    endtask

    task automatic apb_read(input addr_t addr, output word_t rdata, output logic err);
        run_transfer(1'b0, addr, '0, '0, rdata, err);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests.
    ////////////////////////////////////////////////////////////

    task automatic reset_values();
        check_error(pready, 1'b0, "pready after reset");
        check_error(pslverr, 1'b0, "pslverr after reset");
        check_led(led, 2'b00, "after reset");
    endtask

    task automatic rom_readback();
        word_t rdata;
        logic err;
        for (int i = 0; i < ROM_WORDS; i++) begin
            apb_read({REGION_ROM, 28'(i * 4)}, rdata, err);
            check_error(err, 1'b0, $sformatf("ROM word %0d", i));
            check_word(rdata, rom_model[i], $sformatf("ROM word %0d", i));
        end
    endtask

    task automatic ram_strobes();
        word_t data;
        word_t rdata;
        strb_t strb;
        logic err;
        int index;
        // Full words first, so that no byte is left undefined.
        for (int s = 0; s < RAM_SLOTS; s++) begin
            slot_index[s] = int'(random_bits(RAM_BITS));
            data = random_bits(32);
            apb_write(ram_address(slot_index[s]), data, 4'hf, err);
            check_error(err, 1'b0, "RAM full write");
            ram_model[slot_index[s]] = data;
        end
        for (int n = 0; n < STROBE_WRITES; n++) begin
            index = slot_index[random_bits(4)];
            data = random_bits(32);
            strb = strb_t'(random_bits(NUM_LANES));
            apb_write(ram_address(index), data, strb, err);
            check_error(err, 1'b0, "RAM strobe write");
            for (int b = 0; b < NUM_LANES; b++) begin
                if (strb[b]) begin
                    ram_model[index][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
        for (int s = 0; s < RAM_SLOTS; s++) begin
            apb_read(ram_address(slot_index[s]), rdata, err);
            check_error(err, 1'b0, "RAM read");
            check_word(rdata, ram_model[slot_index[s]], $sformatf("RAM word %0d", slot_index[s]));
        end
    endtask

    task automatic led_port();
        addr_t port_addr;
        word_t rdata;
        logic err;
        port_addr = {REGION_PORT, 28'h0};
        apb_write(port_addr, 32'hffff_fffe, 4'b0001, err);
        check_error(err, 1'b0, "port write");
        check_led(led, 2'b10, "port write");
        apb_read(port_addr, rdata, err);
        check_word(rdata, 32'h0000_0002, "port read");
        // Byte 0 not strobed.
        apb_write(port_addr, 32'h0000_0001, 4'b1110, err);
        check_error(err, 1'b0, "port write without byte 0");
        check_led(led, 2'b10, "port write without byte 0");
        apb_read(port_addr, rdata, err);
        check_word(rdata, 32'h0000_0002, "port read");
        apb_write(port_addr, 32'h1234_5671, 4'hf, err);
        check_led(led, 2'b01, "port full write");
        apb_read(port_addr, rdata, err);
        check_word(rdata, 32'h0000_0001, "port read");
    endtask

    task automatic error_responses();
        word_t rdata;
        logic err;
        for (int r = 0; r < 16; r++) begin
            if (r < 1 || r > 3) begin
                run_transfer(1'b0, {4'(r), 28'h0000_010}, '0, '0, rdata, err);
                check_error(err, 1'b1, $sformatf("read of region %0d", r));
                check_word(rdata, '0, $sformatf("read of region %0d", r));
                run_transfer(1'b1, {4'(r), 28'h0000_010}, random_bits(32), 4'hf, rdata, err);
                check_error(err, 1'b1, $sformatf("write to region %0d", r));
                check_word(rdata, '0, $sformatf("write to region %0d", r));
            end
        end
        for (int i = 0; i < 4; i++) begin
            run_transfer(1'b1, {REGION_ROM, 28'(i * 36)}, random_bits(32), 4'hf, rdata, err);
            check_error(err, 1'b1, "ROM write");
            check_word(rdata, '0, "ROM write");
        end
        // Past the RAM depth, on a word that aliases a written slot.
        run_transfer(1'b1, ram_address(RAM_WORDS + slot_index[0]), random_bits(32), 4'hf,
                     rdata, err);
        check_error(err, 1'b1, "RAM write past the end");
        check_word(rdata, '0, "RAM write past the end");
        check_led(led, 2'b01, "after errors");
        for (int s = 0; s < RAM_SLOTS; s++) begin
            apb_read(ram_address(slot_index[s]), rdata, err);
            check_word(rdata, ram_model[slot_index[s]], "RAM after errors");
        end
        rom_readback();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pstrb = '0;
        $readmemh("rom_init.hex", rom_model);
        repeat (2) @(negedge clk);
        reset = 1'b0;
        reset_values();
        rom_readback();
        ram_strobes();
        led_port();
        error_responses();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== filelist.f ====
design/memory_map_pkg.sv
design/apb_addr_decode.sv
design/ram_byte_lane.sv
design/rom_store.sv
design/apb_response.sv
design/memory_map_top.sv
dv/memory_map_tb.sv

// ==== rom_init.hex ====
// One 32-bit program word per line, in hex, for word addresses 0 to 31.
00000093
00000113
000001b3
20000237
0ff00293
00520023
00128293
fe029ce3
30000337
00100393
00732023
00138393
0033f393
00400413
fe841ae3
12345437
67840413
00822223
00422483
00848463
0000006f
deadbeef
cafef00d
0badc0de
a5a5a5a5
5a5a5a5a
01234567
89abcdef
fedcba98
76543210
0f0f0f0f
f0f0f0f0
